// File: soc_interconnect_top.f
logic/soc_mem_map_pkg.sv
logic/soc_bus_pkg.sv
logic/soc_addr_decoder.sv
logic/soc_req_fifo.sv
logic/soc_l2_banks.sv
logic/soc_apb_bridge.sv
logic/soc_target_dispatch.sv
logic/soc_interconnect_top.sv
sim/soc_interconnect_chk.sv
sim/soc_interconnect_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module soc_interconnect_tb \
    -f soc_interconnect_top.f --Mdir obj_dir -o soc_interconnect_sim \
    && ./obj_dir/soc_interconnect_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim/soc_interconnect_tb.sv
/* Testbench for the SoC interconnect: random TCDM traffic checked against
   an L2 word model and an APB slave model, responses compared in order */
`timescale 1ns/10ps

module soc_interconnect_tb;
    import soc_bus_pkg::*;

    localparam int TIMEOUT  = 200;      // Cycles per wait loop
    localparam int L2_WORDS = 1024;     // 4 KiB of L2

    logic        clk_i = 1'b0;
    logic        reset_i, req_i, wen_i, gnt_o, r_valid_o, r_opc_o;
    logic [31:0] add_i, wdata_i, r_rdata_o;
    logic [3:0]  be_i, pstrb_o;
    logic        psel_o, penable_o, pwrite_o, pready_i, pslverr_i;
    logic [31:0] paddr_o, pwdata_o, prdata_i;

    logic [31:0] stim_seed = 32'h5ac2_3742;
    logic [31:0] apb_seed;              // Own stream for the slave delays
    logic [31:0] l2_model [L2_WORDS];
    logic [31:0] exp_data [$];          // Expected responses, oldest first
    logic        exp_opc  [$];
    logic        exp_chk  [$];          // Data compared on reads and errors
    logic [68:0] exp_apb  [$];          // {pwrite, paddr, pwdata, pstrb}
    int          errors, accepted, responses, apb_xfers, stalls, apb_wait;
    logic        hung = 1'b0;           // Set once a wait loop ran out
    logic        long_wait = 1'b0;      // Slow slave for the burst
    logic        pready_nxt = 1'b0;
    logic [31:0] paddr_seen = '0;

    always #4 clk_i = ~clk_i;           // 8 ns period

    soc_interconnect_top #(
        .NR_L2_BANKS (4),
        .BANK_WORDS  (256),
        .FIFO_DEPTH  (4)
    ) uut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Address of one kind, low address bits taken from the upper LCG bits
    function automatic logic [31:0] pick_addr(input logic [1:0] kind, input logic [31:0] r);
        case (kind)
            2'd0:    return {12'h1c0, 8'h00, r[31:22], 2'b00};
            2'd1:    return {12'h000, 8'h00, r[31:22], 2'b00};  // Legacy alias
            2'd2:    return {16'h1a10, r[31:18], 2'b00};
            default: return {4'h3, r[31:6], 2'b00};             // Matches no rule
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, want);
        end
    endtask

    task automatic report_timeout(input string why);
        $display("Timeout: %s", why);
        hung = 1'b1;
    endtask

    // Record the expected outcome of an accepted request, in order
    task automatic expect_rsp(input logic [31:0] a, input logic rd, input logic [31:0] wd,
                              input logic [3:0] be);
        logic [31:0] ra;
        logic [9:0]  idx;
        ra  = (a[31:20] == 12'h000) ? {12'h1c0, a[19:0]} : a;
        idx = ra[11:2];
        if ((ra >= 32'h1c00_0000) && (ra <= 32'h1c00_0fff)) begin
            if (!rd) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) l2_model[idx][8*b +: 8] = wd[8*b +: 8];
                end
            end
            exp_data.push_back(l2_model[idx]);
            exp_opc.push_back(OPC_OK);
            exp_chk.push_back(rd);
        end else if ((ra >= 32'h1a10_0000) && (ra <= 32'h1a10_ffff)) begin
            exp_apb.push_back({!rd, ra, wd, rd ? 4'h0 : be});  // No strobes on reads
            exp_data.push_back(ra ^ 32'hdead_beef);
            exp_opc.push_back(ra[8] ? OPC_ERR : OPC_OK);        // Slave errors on bit 8
            exp_chk.push_back(rd);
        end else begin
            exp_data.push_back('0);
            exp_opc.push_back(OPC_ERR);
            exp_chk.push_back(1'b1);
        end
        accepted++;
    endtask

    // Drive one request and hold it until granted
    task automatic issue(input logic [31:0] a, input logic rd, input logic [31:0] wd,
                         input logic [3:0] be);
        int waited;
        waited = 0;
        @(posedge clk_i);
        req_i   <= 1'b1;
        add_i   <= a;
        wen_i   <= rd;
        wdata_i <= wd;
        be_i    <= be;
        @(negedge clk_i);
        while (!gnt_o && (waited < TIMEOUT)) begin
            stalls++;
            waited++;
            @(negedge clk_i);
        end
        if (!gnt_o) begin
            report_timeout("request was never granted");
        end else begin
            expect_rsp(a, rd, wd, be);                  // Accepted on the next edge
        end
    endtask

    task automatic random_req(input logic [1:0] kind);
        logic [31:0] r1;
        logic [31:0] r2;
        stim_seed = lcg_step(stim_seed);
        r1 = stim_seed;
        stim_seed = lcg_step(stim_seed);
        r2 = stim_seed;
        issue(pick_addr(kind, r1), r2[31], lcg_step(r2), r2[27:24]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB slave model, sampled on the falling edge, driven on the rising one
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin : apb_slave
        logic [68:0] e;
        if (psel_o && !penable_o) begin                 // Setup cycle
            apb_xfers++;
            if (exp_apb.size() == 0) begin
                errors++;
                $display("APB transfer to %h with no peripheral request pending", paddr_o);
            end else begin
                e = exp_apb.pop_front();
                compare("pwrite_o", pwrite_o, e[68]);
                compare("paddr_o", paddr_o, e[67:36]);
                if (e[68]) compare("pwdata_o", pwdata_o, e[35:4]);
                compare("pstrb_o", pstrb_o, e[3:0]);
            end
            apb_seed   = lcg_step(apb_seed);
            apb_wait   = int'(apb_seed[31:30]) + (long_wait ? 8 : 0);
            pready_nxt = (apb_wait == 0);
        end else if (psel_o && penable_o && !pready_i) begin
            apb_wait--;                                 // One more wait state gone
            pready_nxt = (apb_wait == 0);
        end else begin
            pready_nxt = 1'b0;
        end
        paddr_seen = paddr_o;
    end

    always @(posedge clk_i) begin
        pready_i  <= pready_nxt;
        prdata_i  <= paddr_seen ^ 32'hdead_beef;
        pslverr_i <= paddr_seen[8];
    end

    // In-order response check
    always @(negedge clk_i) begin : rsp_check
        logic [31:0] d;
        logic        o;
        logic        c;
        if (!reset_i && r_valid_o) begin
            responses++;
            if (exp_data.size() == 0) begin
                errors++;
                $display("Response seen with no request outstanding");
            end else begin
                d = exp_data.pop_front();
                o = exp_opc.pop_front();
                c = exp_chk.pop_front();
                compare("r_opc_o", r_opc_o, o);
                if (c) compare("r_rdata_o", r_rdata_o, d);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        int          waited;
        logic [31:0] r;
        apb_seed = lcg_step(32'h5ac2_3742);
        reset_i   = 1'b1;
        req_i     = 1'b0;
        add_i     = '0;
        wen_i     = 1'b1;
        wdata_i   = '0;
        be_i      = '0;
        pready_i  = 1'b0;
        prdata_i  = '0;
        pslverr_i = 1'b0;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        // Fill every L2 word so later reads are defined
        for (int i = 0; (i < L2_WORDS) && !hung; i++) begin
            stim_seed = lcg_step(stim_seed);
            issue({20'h1c000, i[9:0], 2'b00}, 1'b0, stim_seed, 4'hf);
        end

        // Random mix of L2, alias, peripheral and unmapped
        for (int i = 0; (i < 400) && !hung; i++) begin
            stim_seed = lcg_step(stim_seed);
            r = stim_seed;
            random_req(r[31:30]);
        end

        // Back-to-back peripheral burst against a slow slave
        long_wait = 1'b1;
        stalls    = 0;
        for (int i = 0; (i < 40) && !hung; i++) random_req(2'd2);
        @(posedge clk_i);
        req_i <= 1'b0;

        waited = 0;
        while (!hung && (exp_data.size() != 0) && (waited < 2000)) begin
            waited++;
            @(negedge clk_i);
        end
        if (!hung && (exp_data.size() != 0)) begin
            report_timeout("responses still missing at end of test");
        end

        if (stalls == 0) begin
            errors++;
            $display("Grant never dropped during the slow burst");
        end
        if (exp_apb.size() != 0) begin
            errors++;
            $display("Expected APB transfers never appeared");
        end
        if (responses != accepted) begin
            errors++;
            $display("Response count differs from accepted request count");
        end
        errors += uut.u_chk.fail_count;                 // Assertion failures

        $display("Summary: %0d errors, %0d accepted, %0d responses, %0d APB transfers",
                 errors, accepted, responses, apb_xfers);
        if ((errors == 0) && !hung) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : soc_interconnect_tb

// File: sim/soc_interconnect_chk.sv
/* APB and response protocol assertions, bound into the interconnect top */
`timescale 1ns/10ps

module soc_interconnect_chk (
    input logic        clk_i,
    input logic        reset_i,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pwrite_i,
    input logic [31:0] paddr_i,
    input logic [31:0] pwdata_i,
    input logic [3:0]  pstrb_i,
    input logic        pready_i,
    input logic        r_valid_i
);

    int fail_count = 0;    // Read back by the testbench

    // Access phase only right after a setup cycle
    penable_after_setup: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(penable_i) |-> $past(psel_i))
        else begin
            fail_count++;
            $error("penable rose without a setup cycle");
        end

    // Fields frozen until the slave is ready
    apb_fields_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (psel_i && !pready_i) |=> (psel_i && $stable(paddr_i) && $stable(pwrite_i)
                                   && $stable(pwdata_i) && $stable(pstrb_i)))
        else begin
            fail_count++;
            $error("APB transfer changed before pready");
        end

    // First cycles may still hold unknowns, later reset cycles must be quiet
    no_rsp_in_reset: assert property (@(posedge clk_i)
        (reset_i && $past(reset_i) && $past(reset_i, 2)) |-> !r_valid_i)
        else begin
            fail_count++;
            $error("r_valid high during reset");
        end

endmodule : soc_interconnect_chk

bind soc_interconnect_top soc_interconnect_chk u_chk (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .psel_i    (psel_o),
    .penable_i (penable_o),
    .pwrite_i  (pwrite_o),
    .paddr_i   (paddr_o),
    .pwdata_i  (pwdata_o),
    .pstrb_i   (pstrb_o),
    .pready_i  (pready_i),
    .r_valid_i (r_valid_o)
);

// File: logic/soc_interconnect_top.sv
/* SoC interconnect for the fabric controller data port: decoder, request
   FIFO and target dispatcher towards L2 and the APB peripherals */
`timescale 1ns/10ps

module soc_interconnect_top
    import soc_bus_pkg::*;
#(
    parameter int NR_L2_BANKS = 4,
    parameter int BANK_WORDS  = 256,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // TCDM slave port
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] add_i,
    input  logic                  wen_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [BE_WIDTH-1:0]   be_i,
    output logic                  gnt_o,
    output logic                  r_valid_o,
    output logic [DATA_WIDTH-1:0] r_rdata_o,
    output logic                  r_opc_o,
    // APB master port
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_WIDTH-1:0] paddr_o,
    output logic [DATA_WIDTH-1:0] pwdata_o,
    output logic [BE_WIDTH-1:0]   pstrb_o,
    input  logic                  pready_i,
    input  logic [DATA_WIDTH-1:0] prdata_i,
    input  logic                  pslverr_i
);

    logic     push, fifo_full, pop, fifo_empty;
    soc_req_t push_req, fifo_head;

    soc_addr_decoder i_addr_decoder (
        .clk_i(clk_i), .reset_i(reset_i),
        .req_i(req_i), .add_i(add_i), .wen_i(wen_i), .wdata_i(wdata_i), .be_i(be_i),
        .gnt_o(gnt_o), .push_o(push), .push_req_o(push_req), .fifo_full_i(fifo_full)
    );

    soc_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_req_fifo (
        .clk_i(clk_i), .reset_i(reset_i),
        .push_i(push), .push_req_i(push_req), .full_o(fifo_full),
        .pop_i(pop), .head_o(fifo_head), .empty_o(fifo_empty)
    );

    soc_target_dispatch #(.NR_L2_BANKS(NR_L2_BANKS), .BANK_WORDS(BANK_WORDS)) i_dispatch (
        .clk_i(clk_i), .reset_i(reset_i),
        .head_i(fifo_head), .empty_i(fifo_empty), .pop_o(pop),
        .r_valid_o(r_valid_o), .r_rdata_o(r_rdata_o), .r_opc_o(r_opc_o),
        .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o),
        .paddr_o(paddr_o), .pwdata_o(pwdata_o), .pstrb_o(pstrb_o),
        .pready_i(pready_i), .prdata_i(prdata_i), .pslverr_i(pslverr_i)
    );

endmodule : soc_interconnect_top

// File: logic/soc_target_dispatch.sv
/* Target dispatcher: starts the FIFO head on the L2 banks, the APB bridge
   or the error path, and returns one response per entry */
`timescale 1ns/10ps

module soc_target_dispatch
    import soc_bus_pkg::*;
#(
    parameter int NR_L2_BANKS = 4,
    parameter int BANK_WORDS  = 256
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Request FIFO side
    input  soc_req_t              head_i,
    input  logic                  empty_i,
    output logic                  pop_o,
    // TCDM response
    output logic                  r_valid_o,
    output logic [DATA_WIDTH-1:0] r_rdata_o,
    output logic                  r_opc_o,
    // APB master
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_WIDTH-1:0] paddr_o,
    output logic [DATA_WIDTH-1:0] pwdata_o,
    output logic [BE_WIDTH-1:0]   pstrb_o,
    input  logic                  pready_i,
    input  logic [DATA_WIDTH-1:0] prdata_i,
    input  logic                  pslverr_i
);

    logic                  busy_q;       // Head has been started
    logic                  start;
    logic                  l2_start, apb_start, err_start;
    logic                  l2_done, apb_done, err_done_q;
    logic                  done;
    logic                  apb_err;
    logic [DATA_WIDTH-1:0] l2_rdata, apb_rdata;

    assign start     = !empty_i && !busy_q;    // One start per FIFO entry
    assign l2_start  = start && (head_i.region == REGION_L2);
    assign apb_start = start && (head_i.region == REGION_PERIPH);
    assign err_start = start && (head_i.region == REGION_NONE);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            err_done_q <= 1'b0;
        end else begin
            err_done_q <= err_start;           // Unmapped answers one cycle later
            if (start) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign done      = l2_done || apb_done || err_done_q;
    assign pop_o     = done;                   // Head leaves with its response
    assign r_valid_o = done;

    // Response data and opcode from whichever target finished
    always_comb begin
        r_rdata_o = '0;
        r_opc_o   = OPC_OK;
        if (l2_done) begin
            r_rdata_o = l2_rdata;
        end else if (apb_done) begin
            r_rdata_o = apb_rdata;
            r_opc_o   = apb_err ? OPC_ERR : OPC_OK;
        end else if (err_done_q) begin
            r_opc_o   = OPC_ERR;               // Zero data, no side effect
        end
    end

    soc_l2_banks #(
        .NR_L2_BANKS (NR_L2_BANKS),
        .BANK_WORDS  (BANK_WORDS)
    ) i_l2_banks (
        .clk_i   (clk_i),
        .start_i (l2_start),
        .wen_i   (head_i.wen),
        .addr_i  (head_i.addr),
        .wdata_i (head_i.wdata),
        .be_i    (head_i.be),
        .done_o  (l2_done),
        .rdata_o (l2_rdata)
    );

    soc_apb_bridge i_apb_bridge (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .start_i   (apb_start),
        .wen_i     (head_i.wen),
        .addr_i    (head_i.addr),
        .wdata_i   (head_i.wdata),
        .be_i      (head_i.be),
        .done_o    (apb_done),
        .rdata_o   (apb_rdata),
        .err_o     (apb_err),
        .psel_o    (psel_o),
        .penable_o (penable_o),
        .pwrite_o  (pwrite_o),
        .paddr_o   (paddr_o),
        .pwdata_o  (pwdata_o),
        .pstrb_o   (pstrb_o),
        .pready_i  (pready_i),
        .prdata_i  (prdata_i),
        .pslverr_i (pslverr_i)
    );

endmodule : soc_target_dispatch

// File: logic/soc_apb_bridge.sv
/* APB master for the peripheral region: one setup cycle, then access
   cycles until pready, response captured on the last one */
`timescale 1ns/10ps

module soc_apb_bridge
    import soc_bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Request from the dispatcher
    input  logic                  start_i,
    input  logic                  wen_i,       // High for read
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [BE_WIDTH-1:0]   be_i,
    output logic                  done_o,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output logic                  err_o,
    // APB master
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_WIDTH-1:0] paddr_o,
    output logic [DATA_WIDTH-1:0] pwdata_o,
    output logic [BE_WIDTH-1:0]   pstrb_o,
    input  logic                  pready_i,
    input  logic [DATA_WIDTH-1:0] prdata_i,
    input  logic                  pslverr_i
);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,      // psel high, penable low
        APB_ACCESS      // Both high until pready
    } apb_state_e;

    apb_state_e            state_q;
    logic                  done_q;
    logic                  wen_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [BE_WIDTH-1:0]   be_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  err_q;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= APB_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                APB_IDLE:   if (start_i) state_q <= APB_SETUP;
                APB_SETUP:  state_q <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready_i) begin          // Slave done, respond next cycle
                        state_q <= APB_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default:    state_q <= APB_IDLE;
            endcase
        end
    end

    // Transfer fields held for the whole transfer
    always_ff @(posedge clk_i) begin
        if ((state_q == APB_IDLE) && start_i) begin
            wen_q   <= wen_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            be_q    <= be_i;
        end
        if ((state_q == APB_ACCESS) && pready_i) begin
            rdata_q <= prdata_i;
            err_q   <= pslverr_i;
        end
    end

    assign psel_o    = (state_q != APB_IDLE);
    assign penable_o = (state_q == APB_ACCESS);
    assign pwrite_o  = !wen_q;
    assign paddr_o   = addr_q;
    assign pwdata_o  = wdata_q;
    assign pstrb_o   = wen_q ? '0 : be_q;   // APB4 wants strobes low on reads

    assign done_o  = done_q;
    assign rdata_o = rdata_q;
    assign err_o   = err_q;

endmodule : soc_apb_bridge

// File: logic/soc_l2_banks.sv
/* Word-interleaved L2 banks with byte-enable writes and registered read
   data one cycle after start */
`timescale 1ns/10ps

module soc_l2_banks
    import soc_bus_pkg::*;
#(
    parameter int NR_L2_BANKS = 4,     // Power of two
    parameter int BANK_WORDS  = 256
) (
    input  logic                  clk_i,
    input  logic                  start_i,
    input  logic                  wen_i,      // High for read
    input  soc_addr_u             addr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [BE_WIDTH-1:0]   be_i,
    output logic                  done_o,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    localparam int BANK_SEL_W = $clog2(NR_L2_BANKS);
    localparam int ROW_W      = $clog2(BANK_WORDS);

    logic [BANK_SEL_W-1:0] bank_sel, bank_sel_q;
    logic [ROW_W-1:0]      row;
    logic [DATA_WIDTH-1:0] bank_rdata [NR_L2_BANKS];
    logic                  done_q;

    // Consecutive words go to consecutive banks
    assign bank_sel = addr_i.ilv.word_idx[BANK_SEL_W-1:0];
    assign row      = addr_i.ilv.word_idx[BANK_SEL_W +: ROW_W];

    for (genvar b = 0; b < NR_L2_BANKS; b++) begin : gen_bank
        logic [DATA_WIDTH-1:0] mem [BANK_WORDS];
        logic [DATA_WIDTH-1:0] rdata_q;
        logic                  bank_hit;

        assign bank_hit = start_i && (bank_sel == BANK_SEL_W'(b));

        always_ff @(posedge clk_i) begin
            if (bank_hit) begin
                if (!wen_i) begin
                    for (int i = 0; i < BE_WIDTH; i++) begin
                        if (be_i[i]) mem[row][8*i +: 8] <= wdata_i[8*i +: 8];  // Byte lane
                    end
                end
                rdata_q <= mem[row];           // Old word on a write
            end
        end

        assign bank_rdata[b] = rdata_q;
    end

    always_ff @(posedge clk_i) begin
        done_q     <= start_i;                 // Fixed one-cycle latency
        bank_sel_q <= bank_sel;
    end

    assign done_o  = done_q;
    assign rdata_o = bank_rdata[bank_sel_q];   // Bank that was addressed

endmodule : soc_l2_banks

// File: logic/soc_req_fifo.sv
/* In-order request FIFO between decoder and dispatcher, circular buffer
   with a registered head so an entry is visible the cycle after push */
`timescale 1ns/10ps

module soc_req_fifo
    import soc_bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     push_i,
    input  soc_req_t push_req_i,
    output logic     full_o,
    input  logic     pop_i,
    output soc_req_t head_o,
    output logic     empty_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    soc_req_t          mem [FIFO_DEPTH];   // Entry storage
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;            // Occupancy
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem[rd_ptr_q];        // Oldest entry

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_req_i;
        end
    end

    // Pointers wrap at FIFO_DEPTH, depth need not be a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;       // Both or neither
            endcase
        end
    end

endmodule : soc_req_fifo

// File: logic/soc_addr_decoder.sv
/* Address decoder: remaps the legacy prefix, matches the region rules
   and grants TCDM requests straight into the request FIFO */
`timescale 1ns/10ps

module soc_addr_decoder
    import soc_bus_pkg::*;
    import soc_mem_map_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    // TCDM master side
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] add_i,
    input  logic                  wen_i,        // High for read
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [BE_WIDTH-1:0]   be_i,
    output logic                  gnt_o,
    // Request FIFO side
    output logic                  push_o,
    output soc_req_t              push_req_o,
    input  logic                  fifo_full_i
);

    soc_addr_u addr_remap;   // Address after the alias
    region_e   region;
    logic      ready_q;      // Low while the FIFO is being cleared

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    // Legacy alias, 0x000xxxxx reaches 0x1c0xxxxx
    always_comb begin
        addr_remap = add_i;
        if (addr_remap.flat.prefix == ALIAS_PREFIX) begin
            addr_remap.flat.prefix = L2_PREFIX;
        end
    end

    // Region rules, first match wins
    always_comb begin
        if ((addr_remap >= L2_START_ADDR) && (addr_remap <= L2_END_ADDR)) begin
            region = REGION_L2;
        end else if ((addr_remap >= PERIPH_START_ADDR) && (addr_remap <= PERIPH_END_ADDR)) begin
            region = REGION_PERIPH;
        end else begin
            region = REGION_NONE;
        end
    end

    assign gnt_o  = ready_q && !fifo_full_i;   // Grant whenever there is room
    assign push_o = req_i && gnt_o;            // Accepted requests go in the same cycle

    always_comb begin
        push_req_o.addr   = addr_remap;
        push_req_o.wen    = wen_i;
        push_req_o.wdata  = wdata_i;
        push_req_o.be     = be_i;
        push_req_o.region = region;
    end

endmodule : soc_addr_decoder

// File: logic/soc_bus_pkg.sv
/* Bus widths, response opcodes, the decoded request record and the
   two views of an address word used by the interconnect */
package soc_bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = 4;     // One enable per byte lane

    // Response opcode on r_opc
    localparam logic OPC_OK  = 1'b0;
    localparam logic OPC_ERR = 1'b1;

    // Target region of a decoded request
    typedef enum logic [1:0] {
        REGION_L2,
        REGION_PERIPH,
        REGION_NONE      // No rule matched, answered with an error
    } region_e;

    // One address word, seen flat by the decoder and interleaved by the banks
    typedef union packed {
        struct packed {
            logic [11:0] prefix;    // Compared against the alias prefix
            logic [19:0] offset;
        } flat;
        struct packed {
            logic [11:0] prefix;
            logic [17:0] word_idx;  // Bank in the low bits, row above
            logic [1:0]  byte_off;
        } ilv;
    } soc_addr_u;

    // Decoded request as it sits in the request FIFO, 71 bits
    typedef struct packed {
        soc_addr_u             addr;
        logic                  wen;     // High for read
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
        region_e               region;
    } soc_req_t;

endpackage : soc_bus_pkg

// File: logic/soc_mem_map_pkg.sv
/* SoC memory map: bounds of the interleaved L2 and peripheral regions,
   plus the legacy prefix alias of the fabric controller data port */
package soc_mem_map_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Region bounds, inclusive
    ////////////////////////////////////////////////////////////////////////////

    // Interleaved L2, 4 KiB
    localparam logic [31:0] L2_START_ADDR     = 32'h1c00_0000;
    localparam logic [31:0] L2_END_ADDR       = 32'h1c00_0fff;

    // Peripheral region, leaves the chip over APB
    localparam logic [31:0] PERIPH_START_ADDR = 32'h1a10_0000;
    localparam logic [31:0] PERIPH_END_ADDR   = 32'h1a10_ffff;

    ////////////////////////////////////////////////////////////////////////////
    // Legacy alias on address bits 31:20
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [11:0] ALIAS_PREFIX      = 12'h000;  // Prefix seen on the port
    localparam logic [11:0] L2_PREFIX         = 12'h1c0;  // Prefix it is mapped to

endpackage : soc_mem_map_pkg
